// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing --assert -Wno-fatal
TOP       = tb_top
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/cpu_pkg.sv ====
/* Word-addressed 512 x 16 memory, no byte access. Opcodes not listed here run as no-ops;
   ALU function codes 6 and 7 behave as pass_a. */
`default_nettype none

package cpu_pkg;

  // ##########################################################
  // Widths
  // ##########################################################
  localparam int word_w    = 16;              // Data path and register width.
  localparam int adr_w     = 9;               // Word address, 512 words of memory.
  localparam int reg_sel_w = 3;               // Register select width.
  localparam int n_regs    = 1 << reg_sel_w;  // Eight general registers.

  typedef enum logic [3:0] {
    op_ld   = 4'h1,  // Register gets memory word.
    op_st   = 4'h2,  // Memory word gets register.
    op_jmp  = 4'h3,  // P gets address.
    op_jz   = 4'h4,  // P gets address when the register is zero.
    op_alu  = 4'h5,  // Register form, dst gets a func b.
    op_halt = 4'hf   // Stop taking instructions.
  } op_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_pass_a
  } alu_e;

  // Memory reference form: op, register, word address.
  typedef struct packed {
    op_e                  op;
    logic [reg_sel_w-1:0] rsel;
    logic [adr_w-1:0]     adr;
  } mem_fmt_t;

  // Register form. The dst field sits on the same bits as rsel.
  typedef struct packed {
    op_e                  op;
    logic [reg_sel_w-1:0] dst;
    logic [reg_sel_w-1:0] src_a;
    logic [reg_sel_w-1:0] src_b;
    alu_e                 func;
  } reg_fmt_t;

  typedef union packed {
    mem_fmt_t mem_f;  // Load, store and jumps.
    reg_fmt_t reg_f;  // ALU operations.
  } instr_u;

endpackage

`default_nettype wire

// ==== design/cpu_seq.sv ====
/* One instruction at a time. ALU results are written one cycle after the take and loads at
   oper_done; halt is final until reset. */
`default_nettype none
`timescale 1ns/1ps

module cpu_seq (
  input  logic                          alu_clk,
  input  logic                          arst_n,
  input  logic                          instr_valid,
  input  cpu_pkg::instr_u               instr,
  output logic                          instr_take,
  output logic                          flush,
  output logic                          p_load,
  output logic [cpu_pkg::word_w-1:0]    p_target,
  output logic [cpu_pkg::reg_sel_w-1:0] wsel,
  output logic [cpu_pkg::reg_sel_w-1:0] rsel_a,
  output logic [cpu_pkg::reg_sel_w-1:0] rsel_b,
  output logic                          we,
  output logic [cpu_pkg::word_w-1:0]    wdata,
  input  logic [cpu_pkg::word_w-1:0]    rdata_a,
  input  logic [cpu_pkg::word_w-1:0]    rdata_b,
  output logic                          oper_req,
  output logic                          oper_we,
  output logic [cpu_pkg::adr_w-1:0]     oper_adr,
  output logic [cpu_pkg::word_w-1:0]    oper_dat,
  input  logic                          oper_done,
  input  logic [cpu_pkg::word_w-1:0]    oper_rdata,
  output logic                          halted
);

  typedef enum logic [1:0] {st_idle, st_exec, st_mem_wait, st_halt} state_e;

  state_e                     state_q;
  state_e                     state_d;
  cpu_pkg::instr_u            ir_q;     // Executing instruction, loaded at the take.
  cpu_pkg::op_e               op;
  logic                       is_mem;
  logic                       jump;
  logic [cpu_pkg::word_w-1:0] alu_res;

  assign op     = ir_q.mem_f.op;  // Both views share the opcode field.
  assign is_mem = (op == cpu_pkg::op_ld) || (op == cpu_pkg::op_st);

  always_ff @(posedge alu_clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge alu_clk) begin
    if (instr_take) begin
      ir_q <= instr;
    end
  end

  // ##########################################################
  // FSM
  // ##########################################################
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (instr_valid) begin
          state_d = st_exec;  // Take the buffered word.
        end
      end
      st_exec: begin
        if (is_mem) begin
          state_d = st_mem_wait;
        end else if (op == cpu_pkg::op_halt) begin
          state_d = st_halt;
        end else begin
          state_d = st_idle;  // ALU, jumps and no-ops take one cycle.
        end
      end
      st_mem_wait: begin
        if (oper_done) begin
          state_d = st_idle;
        end
      end
      default: state_d = st_halt;  // Only reset leaves halt.
    endcase
  end

  // ##########################################################
  // ALU
  // ##########################################################
  always_comb begin
    case (ir_q.reg_f.func)
      cpu_pkg::alu_add:    alu_res = rdata_a + rdata_b;
      cpu_pkg::alu_sub:    alu_res = rdata_a - rdata_b;
      cpu_pkg::alu_and:    alu_res = rdata_a & rdata_b;
      cpu_pkg::alu_or:     alu_res = rdata_a | rdata_b;
      cpu_pkg::alu_xor:    alu_res = rdata_a ^ rdata_b;
      cpu_pkg::alu_pass_a: alu_res = rdata_a;
      default:             alu_res = rdata_a;  // Spare codes.
    endcase
  end

  assign instr_take = (state_q == st_idle) && instr_valid;
  assign halted     = (state_q == st_halt);

  // The memory form reads its register on port a for store and jz.
  assign rsel_a = (op == cpu_pkg::op_alu) ? ir_q.reg_f.src_a : ir_q.mem_f.rsel;
  assign rsel_b = ir_q.reg_f.src_b;
  assign wsel   = ir_q.reg_f.dst;  // Same bits as mem_f.rsel, so loads use it too.
  assign we     = ((state_q == st_exec) && (op == cpu_pkg::op_alu)) ||
                  ((state_q == st_mem_wait) && oper_done && (op == cpu_pkg::op_ld));
  assign wdata  = (state_q == st_mem_wait) ? oper_rdata : alu_res;

  // Request held from exec until the operand unit is done.
  assign oper_req = ((state_q == st_exec) && is_mem) || (state_q == st_mem_wait);
  assign oper_we  = (op == cpu_pkg::op_st);
  assign oper_adr = ir_q.mem_f.adr;
  assign oper_dat = rdata_a;

  assign jump = (state_q == st_exec) &&
                ((op == cpu_pkg::op_jmp) || ((op == cpu_pkg::op_jz) && (rdata_a == '0)));
  assign p_load   = jump;
  assign flush    = jump;  // One cycle, together with the P load.
  assign p_target = {{(cpu_pkg::word_w - cpu_pkg::adr_w){1'b0}}, ir_q.mem_f.adr};

  // Halt is sticky and nothing is taken afterwards.
  a_halt_final : assert property (@(posedge alu_clk) disable iff (!arst_n)
    halted |=> halted && !instr_take);

endmodule

`default_nettype wire

// ==== design/cpu_top.sv ====
/* Memory is external on one Wishbone classic port. P and PR are brought out for
   observation. */
`default_nettype none
`timescale 1ns/1ps

module cpu_top (
  input  logic                       alu_clk,
  input  logic                       arst_n,
  output logic                       wb_cyc,
  output logic                       wb_stb,
  output logic                       wb_we,
  output logic [cpu_pkg::adr_w-1:0]  wb_adr,
  output logic [cpu_pkg::word_w-1:0] wb_dat_w,
  input  logic [cpu_pkg::word_w-1:0] wb_dat_r,
  input  logic                       wb_ack,
  output logic [cpu_pkg::word_w-1:0] p,
  output logic [cpu_pkg::word_w-1:0] pr,
  output logic                       halted
);

  wb_if fetch_bus ();
  wb_if oper_bus ();
  wb_if mem_bus ();

  logic                          instr_valid;
  cpu_pkg::instr_u               instr;
  logic                          instr_take;
  logic                          fetch_ack;
  logic                          flush;
  logic                          p_load;
  logic [cpu_pkg::word_w-1:0]    p_target;
  logic                          we;
  logic [cpu_pkg::reg_sel_w-1:0] wsel;
  logic [cpu_pkg::reg_sel_w-1:0] rsel_a;
  logic [cpu_pkg::reg_sel_w-1:0] rsel_b;
  logic [cpu_pkg::word_w-1:0]    wdata;
  logic [cpu_pkg::word_w-1:0]    rdata_a;
  logic [cpu_pkg::word_w-1:0]    rdata_b;
  logic                          oper_req;
  logic                          oper_we;
  logic [cpu_pkg::adr_w-1:0]     oper_adr;
  logic [cpu_pkg::word_w-1:0]    oper_dat;
  logic                          oper_done;
  logic [cpu_pkg::word_w-1:0]    oper_rdata;

  // ##########################################################
  // External bus
  // ##########################################################
  assign wb_cyc        = mem_bus.cyc;
  assign wb_stb        = mem_bus.stb;
  assign wb_we         = mem_bus.we;
  assign wb_adr        = mem_bus.adr;
  assign wb_dat_w      = mem_bus.dat_w;
  assign mem_bus.dat_r = wb_dat_r;
  assign mem_bus.ack   = wb_ack;

  p_reg i_p_reg (
    .alu_clk, .arst_n, .fetch_ack, .p_load, .p_target, .instr_take, .p, .pr
  );

  reg_file i_reg_file (
    .alu_clk, .arst_n, .we, .wsel, .rsel_a, .rsel_b, .wdata, .rdata_a, .rdata_b
  );

  fetch_unit i_fetch_unit (
    .alu_clk, .arst_n, .p, .flush, .halted, .instr_take, .instr_valid, .instr,
    .fetch_ack, .bus(fetch_bus)
  );

  operand_unit i_operand_unit (
    .alu_clk, .arst_n, .oper_req, .oper_we, .oper_adr, .oper_dat, .oper_done,
    .oper_rdata, .bus(oper_bus)
  );

  wb_arbiter i_wb_arbiter (
    .alu_clk, .arst_n, .fetch_bus, .oper_bus, .mem_bus
  );

  cpu_seq i_cpu_seq (
    .alu_clk, .arst_n, .instr_valid, .instr, .instr_take, .flush, .p_load, .p_target,
    .wsel, .rsel_a, .rsel_b, .we, .wdata, .rdata_a, .rdata_b, .oper_req, .oper_we,
    .oper_adr, .oper_dat, .oper_done, .oper_rdata, .halted
  );

endmodule

`default_nettype wire

// ==== design/fetch_unit.sv ====
/* One-entry prefetch. A read in flight at a flush still completes and its word is
   dropped; no new read starts once halted. */
`default_nettype none
`timescale 1ns/1ps

module fetch_unit (
  input  logic                       alu_clk,
  input  logic                       arst_n,
  input  logic [cpu_pkg::word_w-1:0] p,
  input  logic                       flush,
  input  logic                       halted,
  input  logic                       instr_take,
  output logic                       instr_valid,
  output cpu_pkg::instr_u            instr,
  output logic                       fetch_ack,
  wb_if.master                       bus
);

  logic                      busy_q;     // Read cycle on the bus.
  logic                      discard_q;  // Word of the running cycle is stale.
  logic                      valid_q;    // Buffer holds a word.
  logic [cpu_pkg::adr_w-1:0] adr_q;      // Held until ack.
  cpu_pkg::instr_u           instr_q;
  logic                      start;

  // Refill as the buffer empties, so the next read overlaps execution.
  assign start = (!valid_q || instr_take) && !busy_q && !halted && !flush;

  // A word returning into a flush or after one is not accepted.
  assign fetch_ack = bus.ack && !discard_q && !flush;

  always_ff @(posedge alu_clk or negedge arst_n) begin
    if (!arst_n) begin
      busy_q    <= 1'b0;
      discard_q <= 1'b0;
      valid_q   <= 1'b0;
    end else begin
      if (bus.ack) begin
        busy_q    <= 1'b0;  // Cycle ends, cyc drops next cycle.
        discard_q <= 1'b0;
      end else if (start) begin
        busy_q <= 1'b1;
      end else if (flush && busy_q) begin
        discard_q <= 1'b1;  // Let the cycle finish, drop its word.
      end
      if (flush) begin
        valid_q <= 1'b0;
      end else if (fetch_ack) begin
        valid_q <= 1'b1;
      end else if (instr_take) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge alu_clk) begin
    if (start) begin
      adr_q <= p[cpu_pkg::adr_w-1:0];  // P is stable here, no jump in this cycle.
    end
    if (fetch_ack) begin
      instr_q <= bus.dat_r;
    end
  end

  assign bus.cyc     = busy_q;
  assign bus.stb     = busy_q;
  assign bus.we      = 1'b0;  // Fetch only reads.
  assign bus.adr     = adr_q;
  assign bus.dat_w   = '0;
  assign instr_valid = valid_q;
  assign instr       = instr_q;

endmodule

`default_nettype wire

// ==== design/operand_unit.sv ====
/* One Wishbone cycle per request. oper_done pulses the cycle after ack, with the read data
   already registered. */
`default_nettype none
`timescale 1ns/1ps

module operand_unit (
  input  logic                       alu_clk,
  input  logic                       arst_n,
  input  logic                       oper_req,
  input  logic                       oper_we,
  input  logic [cpu_pkg::adr_w-1:0]  oper_adr,
  input  logic [cpu_pkg::word_w-1:0] oper_dat,
  output logic                       oper_done,
  output logic [cpu_pkg::word_w-1:0] oper_rdata,
  wb_if.master                       bus
);

  logic                       busy_q;
  logic                       done_q;
  logic                       we_q;
  logic [cpu_pkg::adr_w-1:0]  adr_q;
  logic [cpu_pkg::word_w-1:0] dat_q;
  logic [cpu_pkg::word_w-1:0] rdata_q;
  logic                       start;

  // The request is still high in the done cycle, which must not restart.
  assign start = oper_req && !busy_q && !done_q;

  always_ff @(posedge alu_clk or negedge arst_n) begin
    if (!arst_n) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= bus.ack;  // One pulse per finished cycle.
      if (bus.ack) begin
        busy_q <= 1'b0;
      end else if (start) begin
        busy_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge alu_clk) begin
    if (start) begin
      we_q  <= oper_we;  // Held for the whole cycle.
      adr_q <= oper_adr;
      dat_q <= oper_dat;
    end
    if (bus.ack) begin
      rdata_q <= bus.dat_r;
    end
  end

  assign bus.cyc    = busy_q;
  assign bus.stb    = busy_q;
  assign bus.we     = busy_q && we_q;  // Low whenever the bus is idle.
  assign bus.adr    = adr_q;
  assign bus.dat_w  = dat_q;
  assign oper_done  = done_q;
  assign oper_rdata = rdata_q;

  // The sequencer keeps asking until the access has completed.
  a_req_held : assert property (@(posedge alu_clk) disable iff (!arst_n)
    oper_req && !oper_done |=> oper_req);

endmodule

`default_nettype wire

// ==== design/p_reg.sv ====
/* P counts accepted fetches and a jump load wins over them. PR is only valid once an
   instruction has been taken. */
`default_nettype none
`timescale 1ns/1ps

module p_reg (
  input  logic                       alu_clk,
  input  logic                       arst_n,
  input  logic                       fetch_ack,
  input  logic                       p_load,
  input  logic [cpu_pkg::word_w-1:0] p_target,
  input  logic                       instr_take,
  output logic [cpu_pkg::word_w-1:0] p,
  output logic [cpu_pkg::word_w-1:0] pr
);

  logic [cpu_pkg::word_w-1:0] shadow_q;  // Address of the word now in the fetch buffer.
  logic                       shadow_vld_q;

  always_ff @(posedge alu_clk or negedge arst_n) begin
    if (!arst_n) begin
      p            <= '0;
      pr           <= '0;
      shadow_q     <= '0;
      shadow_vld_q <= 1'b0;
    end else begin
      if (p_load) begin
        p            <= p_target;  // A jump wins over a fetch ending in the same cycle.
        shadow_vld_q <= 1'b0;      // The buffered word is flushed with it.
      end else if (fetch_ack) begin
        p            <= p + 1'b1;  // Points past the word just fetched.
        shadow_q     <= p;         // P still holds the fetched address here.
        shadow_vld_q <= 1'b1;
      end else if (instr_take) begin
        shadow_vld_q <= 1'b0;      // The buffer is emptied by the take.
      end
      if (instr_take) begin
        pr <= shadow_q;  // PR names the instruction now executing.
      end
    end
  end

  // The sequencer may only take a word whose address was captured here.
  a_take_shadow : assert property (@(posedge alu_clk) disable iff (!arst_n)
    instr_take |-> shadow_vld_q);

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
/* Eight registers, combinational reads. Register 0 always reads as zero and should not be
   written. */
`default_nettype none
`timescale 1ns/1ps

module reg_file (
  input  logic                          alu_clk,
  input  logic                          arst_n,
  input  logic                          we,
  input  logic [cpu_pkg::reg_sel_w-1:0] wsel,
  input  logic [cpu_pkg::reg_sel_w-1:0] rsel_a,
  input  logic [cpu_pkg::reg_sel_w-1:0] rsel_b,
  input  logic [cpu_pkg::word_w-1:0]    wdata,
  output logic [cpu_pkg::word_w-1:0]    rdata_a,
  output logic [cpu_pkg::word_w-1:0]    rdata_b
);

  logic [cpu_pkg::word_w-1:0] regs [cpu_pkg::n_regs];

  always_ff @(posedge alu_clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < cpu_pkg::n_regs; i++) begin
        regs[i] <= '0;  // All registers start at zero.
      end
    end else if (we) begin
      regs[wsel] <= wdata;  // Single write port.
    end
  end

  // Register 0 is wired to zero on both read ports.
  assign rdata_a = (rsel_a == '0) ? '0 : regs[rsel_a];
  assign rdata_b = (rsel_b == '0) ? '0 : regs[rsel_b];

  // The sequencer never targets register 0 with a valid program.
  a_no_r0_write : assert property (@(posedge alu_clk) disable iff (!arst_n)
    we |-> (wsel != '0));

endmodule

`default_nettype wire

// ==== design/wb_arbiter.sv ====
/* Two masters, operand unit first. The grant only moves while the bus is idle, which
   costs one cycle before the first request after idle. */
`default_nettype none
`timescale 1ns/1ps

module wb_arbiter (
  input logic  alu_clk,
  input logic  arst_n,
  wb_if.slave  fetch_bus,
  wb_if.slave  oper_bus,
  wb_if.master mem_bus
);

  logic active_q;    // A granted cycle owns the bus.
  logic oper_gnt_q;  // Operand unit owns it, else fetch.

  // ##########################################################
  // Grant
  // ##########################################################
  always_ff @(posedge alu_clk or negedge arst_n) begin
    if (!arst_n) begin
      active_q   <= 1'b0;
      oper_gnt_q <= 1'b0;
    end else if (!active_q) begin
      if (oper_bus.cyc) begin
        active_q   <= 1'b1;
        oper_gnt_q <= 1'b1;  // Operand wins a tie.
      end else if (fetch_bus.cyc) begin
        active_q   <= 1'b1;
        oper_gnt_q <= 1'b0;
      end
    end else if (mem_bus.ack) begin
      active_q <= 1'b0;  // The master drops cyc at this same edge.
    end
  end

  // ##########################################################
  // Bus mux
  // ##########################################################
  assign mem_bus.cyc   = active_q && (oper_gnt_q ? oper_bus.cyc : fetch_bus.cyc);
  assign mem_bus.stb   = active_q && (oper_gnt_q ? oper_bus.stb : fetch_bus.stb);
  assign mem_bus.we    = active_q && (oper_gnt_q ? oper_bus.we : fetch_bus.we);
  assign mem_bus.adr   = oper_gnt_q ? oper_bus.adr : fetch_bus.adr;
  assign mem_bus.dat_w = oper_gnt_q ? oper_bus.dat_w : fetch_bus.dat_w;

  // Read data goes to both, ack only to the owner.
  assign oper_bus.dat_r  = mem_bus.dat_r;
  assign fetch_bus.dat_r = mem_bus.dat_r;
  assign oper_bus.ack    = mem_bus.ack && active_q && oper_gnt_q;
  assign fetch_bus.ack   = mem_bus.ack && active_q && !oper_gnt_q;

  a_stb_cyc : assert property (@(posedge alu_clk) disable iff (!arst_n)
    mem_bus.stb |-> mem_bus.cyc);

  // A running cycle keeps its owner until it is over.
  a_gnt_stable : assert property (@(posedge alu_clk) disable iff (!arst_n)
    mem_bus.cyc |=> $stable(oper_gnt_q));

endmodule

`default_nettype wire

// ==== design/wb_if.sv ====
/* Wishbone classic, single transfers only. The master holds adr, we and dat_w until ack. */
`default_nettype none
`timescale 1ns/1ps

interface wb_if;

  logic                       cyc;    // Cycle in progress.
  logic                       stb;    // Transfer strobe, never without cyc.
  logic                       we;     // High for a write.
  logic [cpu_pkg::adr_w-1:0]  adr;    // Word address.
  logic [cpu_pkg::word_w-1:0] dat_w;  // Write data.
  logic [cpu_pkg::word_w-1:0] dat_r;  // Read data, valid with ack.
  logic                       ack;    // One pulse per cycle.

  modport master (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, ack
  );

endinterface

`default_nettype wire

// ==== tb.f ====
design/cpu_pkg.sv
design/wb_if.sv
design/p_reg.sv
design/reg_file.sv
design/fetch_unit.sv
design/operand_unit.sv
design/wb_arbiter.sv
design/cpu_seq.sv
design/cpu_top.sv
tb/tb_mem.sv
tb/tb_top.sv

// ==== tb/tb_mem.sv ====
/* Behavioral 512 x 16 word memory with a fixed program at 0 and data at 0x100.
   Acks after 0 to 3 random wait states and drives its outputs on the falling edge. */
`default_nettype none
`timescale 1ns/1ps

module tb_mem (
  input  logic                       clk,
  input  logic                       cyc,
  input  logic                       stb,
  input  logic                       we,
  input  logic [cpu_pkg::adr_w-1:0]  adr,
  input  logic [cpu_pkg::word_w-1:0] dat_w,
  output logic [cpu_pkg::word_w-1:0] dat_r,
  output logic                       ack
);

  localparam int depth = 1 << cpu_pkg::adr_w;

  logic [15:0] mem [depth];
  integer      seed      = 13210;  // Fixed seed, so every run sees the same wait states.
  integer      rnd;
  int          wait_left = -1;     // Wait states left, -1 while no cycle is served.

  // Hand-assembled program, four words per line starting at address 0x00.
  logic [15:0] prog [32] = '{
    16'h1300, 16'h1501, 16'h2380, 16'h5650,  // ld r1, ld r2, st r1, add r3.
    16'h2781, 16'h5851, 16'h2982, 16'h5A52,  // st r3, sub r4, st r4, and r5.
    16'h2B83, 16'h5C53, 16'h2D84, 16'h5E54,  // st r5, or r6, st r6, xor r7.
    16'h2F85, 16'h5685, 16'h2786, 16'h3014,  // st r7, pass_a r3, st r3, jmp 0x14.
    16'h23F0, 16'h25F1, 16'h27F2, 16'hF000,  // Skipped by the jump.
    16'h4220, 16'h2587, 16'h584C, 16'h481A,  // jz r1 not taken, st r2, r4 = 0, jz r4.
    16'h23F3, 16'hF000, 16'h2F88, 16'h0000,  // Two skipped words, st r7, a no-op.
    16'h2B89, 16'hF000, 16'h0000, 16'h0000   // st r5, halt, then padding.
  };

  initial begin
    dat_r <= '0;
    ack   <= 1'b0;
    for (int i = 0; i < depth; i++) begin
      mem[i] = (i < 32) ? prog[i] : 16'h0000;  // Unused words decode as no-ops.
    end
    mem[9'h100] = 16'h1234;  // Source of ld r1.
    mem[9'h101] = 16'h0F0F;  // Source of ld r2.
  end

  always @(negedge clk) begin
    if (ack) begin
      ack <= 1'b0;  // Ack is a single pulse, the master drops cyc meanwhile.
    end else if (cyc && stb) begin
      if (wait_left < 0) begin
        rnd       = $random(seed);
        wait_left = rnd[1:0];  // New cycle, draw 0 to 3 wait states.
      end
      if (wait_left == 0) begin
        ack   <= 1'b1;
        dat_r <= mem[adr];
        if (we) begin
          mem[adr] = dat_w;  // Address and data are held until ack.
        end
        wait_left = -1;
      end else begin
        wait_left = wait_left - 1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_top.sv ====
/* Runs the program held in tb_mem and checks bus rules, write cycles and halt with
   concurrent assertions. The store table below is worked out by hand from that program. */
`default_nettype none
`timescale 1ns/1ps

module tb_top;

  localparam int          n_stores       = 10;
  localparam int          timeout_cycles = 2000;  // About 40 instructions of at most 12 cycles.
  localparam int          idle_watch     = 8;     // Cycles of idle bus watched after halt.
  localparam logic [15:0] final_p        = 16'h001F;  // Halt at 0x1D, its take fetches 0x1E.
  localparam logic [8:0]  data_base      = 9'h100;    // Program lies below, data above.

  logic                       alu_clk = 1'b0;
  logic                       arst_n;
  logic                       wb_cyc;
  logic                       wb_stb;
  logic                       wb_we;
  logic [cpu_pkg::adr_w-1:0]  wb_adr;
  logic [cpu_pkg::word_w-1:0] wb_dat_w;
  logic [cpu_pkg::word_w-1:0] wb_dat_r;
  logic                       wb_ack;
  logic [cpu_pkg::word_w-1:0] p;
  logic [cpu_pkg::word_w-1:0] pr;
  logic                       halted;
  logic                       store_ack;
  logic [cpu_pkg::adr_w-1:0]  p_low;
  logic [cpu_pkg::adr_w-1:0]  p_low_prev;       // P one cycle back.
  logic                       seen_cyc = 1'b0;  // Set once the first bus cycle shows up.
  int                         st_idx   = 0;     // Next entry of the store table.
  int                         cycles   = 0;

  // ##########################################################
  // Expected write cycles, in program order
  // ##########################################################
  logic [8:0]  exp_adr [n_stores] = '{9'h180, 9'h181, 9'h182, 9'h183, 9'h184,
                                      9'h185, 9'h186, 9'h187, 9'h188, 9'h189};
  logic [15:0] exp_pr  [n_stores] = '{16'h02, 16'h04, 16'h06, 16'h08, 16'h0A,
                                      16'h0C, 16'h0E, 16'h15, 16'h1A, 16'h1C};
  logic [15:0] exp_dat [n_stores] = '{
    16'h1234,  // Loaded r1 = 1234 stored back.
    16'h2143,  // add, 1234 + 0f0f.
    16'h0325,  // sub, 1234 - 0f0f.
    16'h0204,  // and.
    16'h1F3F,  // or.
    16'h1D3B,  // xor.
    16'h0F0F,  // pass_a of r2.
    16'h0F0F,  // Reached through jmp, after a jz that is not taken.
    16'h1D3B,  // Reached through a taken jz.
    16'h0204   // After a no-op opcode.
  };

  always #50 alu_clk = ~alu_clk;

  cpu_top i_dut (
    .alu_clk, .arst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r,
    .wb_ack, .p, .pr, .halted
  );

  tb_mem i_mem (
    .clk(alu_clk), .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr),
    .dat_w(wb_dat_w), .dat_r(wb_dat_r), .ack(wb_ack)
  );

  assign store_ack = wb_cyc && wb_stb && wb_we && wb_ack;  // A write cycle completes.
  assign p_low     = p[cpu_pkg::adr_w-1:0];

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "Run stopped at the first failure.");
  endtask

  always @(posedge alu_clk) begin
    if (wb_cyc) begin
      seen_cyc <= 1'b1;
    end
    if (store_ack) begin
      st_idx <= st_idx + 1;  // One table entry per completed write.
    end
    p_low_prev <= p_low;
    cycles     <= cycles + 1;
    if (cycles == timeout_cycles) begin
      stop_with_failure($sformatf("Timeout after %0d cycles, the program never halted",
        cycles));
    end
  end

  // ##########################################################
  // Bus, reset and fetch checks
  // ##########################################################
  a_reset_state : assert property (@(posedge alu_clk)
    $rose(arst_n) |-> (p == '0) && (pr == '0) && !halted && !wb_cyc)
    else stop_with_failure($sformatf(
      "Error at %0t: p pr halted wb_cyc expected 0 0 0 0 after reset, got %h %h %b %b",
      $time, $sampled(p), $sampled(pr), $sampled(halted), $sampled(wb_cyc)));

  a_first_read : assert property (@(posedge alu_clk) disable iff (!arst_n)
    wb_cyc && !seen_cyc |-> !wb_we && (wb_adr == '0))
    else stop_with_failure($sformatf(
      "Error at %0t: first cycle wb_we/wb_adr expected 0/000, got %b/%h",
      $time, $sampled(wb_we), $sampled(wb_adr)));

  // The read address was taken from P the cycle before the arbiter put it on the bus.
  // Reads in the data area come from loads and are not fetches.
  a_fetch_adr : assert property (@(posedge alu_clk) disable iff (!arst_n)
    $rose(wb_cyc) && !wb_we && (wb_adr < data_base) |-> (wb_adr == p_low_prev))
    else stop_with_failure($sformatf("Error at %0t: wb_adr expected %h, got %h",
      $time, $sampled(p_low_prev), $sampled(wb_adr)));

  a_stb_cyc : assert property (@(posedge alu_clk) disable iff (!arst_n) wb_stb |-> wb_cyc)
    else stop_with_failure("Bus strobe seen without an active cycle");

  // One ack ends each cycle and cyc drops right after it.
  a_ack_once : assert property (@(posedge alu_clk) disable iff (!arst_n)
    wb_ack |-> wb_cyc && wb_stb ##1 !wb_cyc)
    else stop_with_failure("Bus cycle still open after its ack, or ack outside a cycle");

  // ##########################################################
  // Write cycles against the store table
  // ##########################################################
  a_store_count : assert property (@(posedge alu_clk) disable iff (!arst_n)
    store_ack |-> (st_idx < n_stores))
    else stop_with_failure("A write cycle appeared beyond the expected store table");

  a_store_adr : assert property (@(posedge alu_clk) disable iff (!arst_n)
    store_ack && (st_idx < n_stores) |-> (wb_adr == exp_adr[st_idx]))
    else stop_with_failure($sformatf("Error at %0t: wb_adr expected %h, got %h",
      $time, exp_adr[$sampled(st_idx)], $sampled(wb_adr)));

  a_store_dat : assert property (@(posedge alu_clk) disable iff (!arst_n)
    store_ack && (st_idx < n_stores) |-> (wb_dat_w == exp_dat[st_idx]))
    else stop_with_failure($sformatf("Error at %0t: wb_dat_w expected %h, got %h",
      $time, exp_dat[$sampled(st_idx)], $sampled(wb_dat_w)));

  a_store_pr : assert property (@(posedge alu_clk) disable iff (!arst_n)
    store_ack && (st_idx < n_stores) |-> (pr == exp_pr[st_idx]))
    else stop_with_failure($sformatf("Error at %0t: pr expected %h, got %h",
      $time, exp_pr[$sampled(st_idx)], $sampled(pr)));

  // Once halted and idle the bus stays quiet and P is frozen.
  a_halt_quiet : assert property (@(posedge alu_clk) disable iff (!arst_n)
    halted && !wb_cyc |=> !wb_cyc && $stable(p))
    else stop_with_failure("A bus cycle started or p moved after halt");

  initial begin
    arst_n = 1'b0;
    repeat (3) @(negedge alu_clk);
    arst_n = 1'b1;
    @(negedge alu_clk);
    while (!(halted && !wb_cyc)) begin
      @(negedge alu_clk);  // The fetch started by the halt take must drain first.
    end
    repeat (idle_watch) @(negedge alu_clk);
    if ((st_idx == n_stores) && (p == final_p)) begin
      $display("Everything OK");
      $finish;
    end else begin
      stop_with_failure($sformatf(
        "Error at %0t: stores expected %0d got %0d, p expected %h got %h",
        $time, n_stores, st_idx, final_p, p));
    end
  end

endmodule

`default_nettype wire
